// ==== include/lumi_rx_cfg.svh ====
`ifndef LUMI_RX_CFG_SVH
`define LUMI_RX_CFG_SVH

// Packet field widths
`define LUMI_CW  32      // Command
`define LUMI_AW  32      // Each address
`define LUMI_DW  64      // Largest data field
`define LUMI_IOW 32      // PHY beat, 4 bytes

// Queue sizes in beats
`define LUMI_FIFO_DEPTH 16      // Request and response
`define LUMI_LNK_DEPTH  4       // Link commands

// Opcodes, low five command bits
`define LUMI_OP_READ   5'd1     // Request, no data
`define LUMI_OP_WRITE  5'd3     // Request with data
`define LUMI_OP_POSTED 5'd5     // Request with data
`define LUMI_OP_RDRESP 5'd2     // Response with data
`define LUMI_OP_WRRESP 5'd4     // Response, no data
`define LUMI_OP_LINK   5'd31    // Command only

// Link subcodes, command bits 15..8
`define LUMI_CRDT_REQ_A  8'h01
`define LUMI_CRDT_REQ_B  8'h02
`define LUMI_CRDT_RESP_A 8'h11
`define LUMI_CRDT_RESP_B 8'h12

`endif

// ==== hdl/lumi_rx_pkg.sv ====
`include "lumi_rx_cfg.svh"

package lumi_rx_pkg;

   // Beats per header part
   localparam logic [7:0] CMD_BEATS = `LUMI_CW / `LUMI_IOW;
   localparam logic [7:0] HDR_BEATS = (`LUMI_CW + 2 * `LUMI_AW) / `LUMI_IOW;

   // Queue a packet is steered to
   typedef enum logic [1:0]
   {
      CLS_NONE = 2'd0,     // Invalid opcode, dropped
      CLS_REQ  = 2'd1,
      CLS_RESP = 2'd2,
      CLS_LINK = 2'd3
   } pkt_class_t;

   // One queued beat, 35 bits
   typedef struct packed
   {
      logic [`LUMI_IOW-1:0] data;
      logic                 eop;      // Last beat of its packet
      pkt_class_t           cls;
   } rx_beat_t;

   // Reassembled packet, 160 bits
   typedef struct packed
   {
      logic [`LUMI_CW-1:0] cmd;
      logic [`LUMI_AW-1:0] dstaddr;
      logic [`LUMI_AW-1:0] srcaddr;
      logic [`LUMI_DW-1:0] data;
   } umi_pkt_t;

   // Link and invalid opcodes carry the command alone
   function automatic logic is_cmd_only(input logic [`LUMI_CW-1:0] cmd);
      logic [4:0] op;
      op = cmd[4:0];
      return !(op inside {`LUMI_OP_READ, `LUMI_OP_WRITE, `LUMI_OP_POSTED,
                          `LUMI_OP_RDRESP, `LUMI_OP_WRRESP});
   endfunction

   // Header without data
   function automatic logic is_no_data(input logic [`LUMI_CW-1:0] cmd);
      return (cmd[4:0] == `LUMI_OP_READ) || (cmd[4:0] == `LUMI_OP_WRRESP);
   endfunction

   // (len+1) << size
   function automatic logic [15:0] pkt_bytes(input logic [`LUMI_CW-1:0] cmd);
      logic [15:0] lenp1;
      lenp1 = {8'd0, cmd[15:8]} + 16'd1;
      return lenp1 << cmd[7:5];
   endfunction

   // Packet length in beats, sizes of 2 and up give whole beats
   function automatic logic [7:0] pkt_beats(input logic [`LUMI_CW-1:0] cmd);
      logic [15:0] data_beats;
      data_beats = pkt_bytes(cmd) / (`LUMI_IOW / 8);
      if (is_cmd_only(cmd))
         return CMD_BEATS;
      else if (is_no_data(cmd))
         return HDR_BEATS;
      else
         return HDR_BEATS + data_beats[7:0];
   endfunction

endpackage

// ==== hdl/lumi_beat_if.sv ====
`timescale 1ns/1ns
`include "lumi_rx_cfg.svh"

// Queued beats, arbiter towards assembler
interface lumi_beat_if;

   logic                 valid;   // Held until the beat moves
   logic                 ready;
   logic [`LUMI_IOW-1:0] data;
   logic                 eop;     // Last beat of packet

   modport source
   (
      output valid, data, eop,
      input  ready
   );

   modport sink
   (
      input  valid, data, eop,
      output ready
   );

endinterface

// ==== hdl/lumi_pkt_if.sv ====
`timescale 1ns/1ns

// Whole packets, output register towards port split
interface lumi_pkt_if;

   logic                   valid;
   logic                   ready;   // From the port the packet goes to
   lumi_rx_pkg::umi_pkt_t  pkt;

   modport source
   (
      output valid, pkt,
      input  ready
   );

   modport sink
   (
      input  valid, pkt,
      output ready
   );

endinterface

// ==== hdl/lumi_rx_fifo.sv ====
`timescale 1ns/1ns

module lumi_rx_fifo
#(
   parameter int DEPTH = 16     // Power of two
)
(
   input  logic                  clk,
   input  logic                  nreset,
   input  logic                  wr_en,
   input  lumi_rx_pkg::rx_beat_t din,
   input  logic                  rd_en,
   output lumi_rx_pkg::rx_beat_t dout,   // Head of queue, no read latency
   output logic                  empty
);

   localparam int PW = $clog2(DEPTH);

   lumi_rx_pkg::rx_beat_t mem [DEPTH];
   logic [PW:0]           wr_ptr;        // Extra bit tells full from empty
   logic [PW:0]           rd_ptr;
   logic                  full;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
   assign dout  = mem[rd_ptr[PW-1:0]];   // Fall-through read

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
         mem[wr_ptr[PW-1:0]] <= din;
   end

   // Remote side must stay within its credits
   a_no_overflow: assert property (@(posedge clk) disable iff (!nreset)
      wr_en |-> !full);

   a_no_underflow: assert property (@(posedge clk) disable iff (!nreset)
      rd_en |-> !empty);

endmodule

// ==== hdl/lumi_rx_sampler.sv ====
`timescale 1ns/1ns
`include "lumi_rx_cfg.svh"

module lumi_rx_sampler
(
   input  logic                  clk,
   input  logic                  nreset,
   input  logic [`LUMI_IOW-1:0]  phy_rxdata,
   input  logic                  phy_rxvld,
   output lumi_rx_pkg::rx_beat_t beat,       // Registered beat with tags
   output logic                  wr_valid
);

   logic [7:0]              cnt;          // Beat index in packet
   logic [7:0]              beats_keep;   // Length taken at first beat
   lumi_rx_pkg::pkt_class_t cls_keep;
   lumi_rx_pkg::pkt_class_t cls_dec;      // Class of the beat on the pins
   lumi_rx_pkg::pkt_class_t cls_now;
   logic [7:0]              beats_now;
   logic                    sop;
   logic                    last;

   //############################
   // Boundary tracking
   //############################

   assign sop = (cnt == 8'd0);  // Next beat opens a packet

   // First beat holds the command
   always_comb
   begin
      case (phy_rxdata[4:0])
         `LUMI_OP_READ, `LUMI_OP_WRITE, `LUMI_OP_POSTED: cls_dec = lumi_rx_pkg::CLS_REQ;
         `LUMI_OP_RDRESP, `LUMI_OP_WRRESP:                cls_dec = lumi_rx_pkg::CLS_RESP;
         `LUMI_OP_LINK:                                  cls_dec = lumi_rx_pkg::CLS_LINK;
         default:                                        cls_dec = lumi_rx_pkg::CLS_NONE;
      endcase
   end

   assign beats_now = sop ? lumi_rx_pkg::pkt_beats(phy_rxdata) : beats_keep;
   assign cls_now   = sop ? cls_dec : cls_keep;
   assign last      = (cnt + 8'd1 == beats_now);   // Counter wraps here

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         cnt        <= 8'd0;
         beats_keep <= 8'd0;
         cls_keep   <= lumi_rx_pkg::CLS_NONE;
         wr_valid   <= 1'b0;
      end
      else
      begin
         wr_valid <= phy_rxvld;
         if (phy_rxvld)
         begin
            cnt <= last ? 8'd0 : cnt + 8'd1;
            // Hold length and class for the rest of the packet
            if (sop)
            begin
               beats_keep <= beats_now;
               cls_keep   <= cls_dec;
            end
         end
      end
   end

   // Input register, qualified by wr_valid
   always_ff @(posedge clk)
   begin
      beat.data <= phy_rxdata;
      beat.eop  <= last;
      beat.cls  <= cls_now;
   end

   // Data field fits the 64 bit packet data
   a_data_size: assert property (@(posedge clk) disable iff (!nreset)
      phy_rxvld && sop && !lumi_rx_pkg::is_cmd_only(phy_rxdata)
      && !lumi_rx_pkg::is_no_data(phy_rxdata)
      |-> lumi_rx_pkg::pkt_bytes(phy_rxdata) <= 16'd8);

endmodule

// ==== hdl/lumi_rx_queues.sv ====
`timescale 1ns/1ns
`include "lumi_rx_cfg.svh"

module lumi_rx_queues
(
   input  logic                  clk,
   input  logic                  nreset,
   input  logic                  csr_en,
   input  logic [15:0]           csr_crdt_req_init,
   input  logic [15:0]           csr_crdt_resp_init,
   input  lumi_rx_pkg::rx_beat_t beat,
   input  logic                  wr_valid,
   output logic [15:0]           loc_crdt_req,
   output logic [15:0]           loc_crdt_resp,
   lumi_beat_if.source           bif
);

   // Index 0 request, 1 response, 2 link
   lumi_rx_pkg::rx_beat_t dout [3];
   lumi_rx_pkg::rx_beat_t head;          // Beat of the chosen FIFO
   logic [2:0]            wr_en;
   logic [2:0]            rd_en;
   logic [2:0]            empty;
   logic [2:0]            sel_q;         // Locked choice
   logic [2:0]            sel_now;
   logic                  locked;

   //############################
   // Class FIFOs
   //############################

   assign wr_en[0] = wr_valid && (beat.cls == lumi_rx_pkg::CLS_REQ);
   assign wr_en[1] = wr_valid && (beat.cls == lumi_rx_pkg::CLS_RESP);
   assign wr_en[2] = wr_valid && (beat.cls == lumi_rx_pkg::CLS_LINK);  // CLS_NONE dropped

   for (genvar i = 0; i < 3; i++)
   begin : g_fifo
      lumi_rx_fifo #(.DEPTH(i == 2 ? `LUMI_LNK_DEPTH : `LUMI_FIFO_DEPTH)) u_fifo
      (
         .clk    (clk),
         .nreset (nreset),
         .wr_en  (wr_en[i]),
         .din    (beat),
         .rd_en  (rd_en[i]),
         .dout   (dout[i]),
         .empty  (empty[i])
      );
   end

   //############################
   // Packet arbiter
   //############################

   // Link first, then response, then request
   assign sel_now = locked     ? sel_q  :
                    !empty[2]  ? 3'b100 :
                    !empty[1]  ? 3'b010 :
                    !empty[0]  ? 3'b001 : 3'b000;

   assign head = sel_now[2] ? dout[2] :
                 sel_now[1] ? dout[1] : dout[0];

   assign bif.valid = |(sel_now & ~empty);
   assign bif.data  = head.data;
   assign bif.eop   = head.eop;
   assign rd_en     = sel_now & ~empty & {3{bif.ready}};

   // Lock from the first offered beat until eop moves
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         locked <= 1'b0;
         sel_q  <= 3'b000;
      end
      else if (bif.valid)
      begin
         sel_q  <= sel_now;
         locked <= !(bif.ready && head.eop);
      end
   end

   //############################
   // Local credits
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         loc_crdt_req  <= 16'd0;
         loc_crdt_resp <= 16'd0;
      end
      else if (!csr_en)
      begin
         loc_crdt_req  <= csr_crdt_req_init;
         loc_crdt_resp <= csr_crdt_resp_init;
      end
      else
      begin
         if (rd_en[0])
            loc_crdt_req <= loc_crdt_req + 16'd1;    // One per beat freed
         if (rd_en[1])
            loc_crdt_resp <= loc_crdt_resp + 16'd1;
      end
   end

   // Offered beat is not withdrawn
   a_valid_hold: assert property (@(posedge clk) disable iff (!nreset)
      bif.valid && !bif.ready |=> bif.valid && $stable(bif.data));

endmodule

// ==== hdl/lumi_rx_assembler.sv ====
`timescale 1ns/1ns
`include "lumi_rx_cfg.svh"

module lumi_rx_assembler
(
   input  logic                clk,
   input  logic                nreset,
   lumi_beat_if.sink           bif,
   // Request port
   output logic [`LUMI_CW-1:0] umi_req_out_cmd,
   output logic [`LUMI_AW-1:0] umi_req_out_dstaddr,
   output logic [`LUMI_AW-1:0] umi_req_out_srcaddr,
   output logic [`LUMI_DW-1:0] umi_req_out_data,
   output logic                umi_req_out_valid,
   input  logic                umi_req_out_ready,
   // Response port
   output logic [`LUMI_CW-1:0] umi_resp_out_cmd,
   output logic [`LUMI_AW-1:0] umi_resp_out_dstaddr,
   output logic [`LUMI_AW-1:0] umi_resp_out_srcaddr,
   output logic [`LUMI_DW-1:0] umi_resp_out_data,
   output logic                umi_resp_out_valid,
   input  logic                umi_resp_out_ready,
   // Remote credits
   output logic [15:0]         rmt_crdt_req,
   output logic [15:0]         rmt_crdt_resp
);

   localparam int PW = `LUMI_CW + 2 * `LUMI_AW + `LUMI_DW;   // 160
   localparam int BW = $clog2(PW / 8);                      // Byte offset bits
   localparam logic [BW-1:0] BPB = BW'(`LUMI_IOW / 8);      // Bytes per beat

   logic [PW-1:0]         shiftreg;
   logic [PW-1:0]         sr_next;   // Including the beat now offered
   logic [BW-1:0]         boff;      // Byte offset of next beat
   logic [`LUMI_CW-1:0]   cmd_next;
   logic                  move;
   logic                  done;      // Eop beat moves
   logic                  link;
   lumi_rx_pkg::umi_pkt_t pkt_next;

   lumi_pkt_if u_pkt_if ();

   //############################
   // Shift register
   //############################

   assign move = bif.valid && bif.ready;
   assign done = move && bif.eop;

   // Eop waits while a held packet is not taken
   assign bif.ready = !bif.eop || !u_pkt_if.valid || u_pkt_if.ready;

   always_comb
   begin
      sr_next = shiftreg;
      if (boff == '0)
         sr_next = '0;   // Packet start clears old bytes
      sr_next[{boff, 3'b000} +: `LUMI_IOW] = bif.data;
   end

   always_ff @(posedge clk)
   begin
      if (move)
         shiftreg <= sr_next;
   end

   assign cmd_next = sr_next[`LUMI_CW-1:0];
   assign link     = (cmd_next[4:0] == `LUMI_OP_LINK);

   // Field masking
   always_comb
   begin
      pkt_next.cmd     = cmd_next;
      pkt_next.dstaddr = sr_next[`LUMI_CW +: `LUMI_AW];
      pkt_next.srcaddr = sr_next[`LUMI_CW + `LUMI_AW +: `LUMI_AW];
      pkt_next.data    = sr_next[`LUMI_CW + 2 * `LUMI_AW +: `LUMI_DW];
      if (lumi_rx_pkg::is_cmd_only(cmd_next))
      begin
         pkt_next.dstaddr = '0;
         pkt_next.srcaddr = '0;
      end
      if (lumi_rx_pkg::is_cmd_only(cmd_next) || lumi_rx_pkg::is_no_data(cmd_next))
         pkt_next.data = '0;
   end

   //############################
   // Output register and credits
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         boff           <= '0;
         u_pkt_if.valid <= 1'b0;
         rmt_crdt_req   <= 16'd0;
         rmt_crdt_resp  <= 16'd0;
      end
      else
      begin
         if (move)
            boff <= bif.eop ? '0 : boff + BPB;
         if (done && !link)
            u_pkt_if.valid <= 1'b1;       // Held until accepted
         else if (u_pkt_if.ready)
            u_pkt_if.valid <= 1'b0;
         // Link commands stop here
         if (done && link)
         begin
            case (cmd_next[15:8])
               `LUMI_CRDT_REQ_A, `LUMI_CRDT_REQ_B:   rmt_crdt_req  <= cmd_next[31:16];
               `LUMI_CRDT_RESP_A, `LUMI_CRDT_RESP_B: rmt_crdt_resp <= cmd_next[31:16];
               default:                              ;
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (done && !link)
         u_pkt_if.pkt <= pkt_next;
   end

   //############################
   // Port split
   //############################

   // Odd opcodes are requests
   assign umi_req_out_valid  = u_pkt_if.valid && u_pkt_if.pkt.cmd[0];
   assign umi_resp_out_valid = u_pkt_if.valid && !u_pkt_if.pkt.cmd[0];
   assign u_pkt_if.ready     = u_pkt_if.pkt.cmd[0] ? umi_req_out_ready : umi_resp_out_ready;

   assign umi_req_out_cmd      = u_pkt_if.pkt.cmd;
   assign umi_req_out_dstaddr  = u_pkt_if.pkt.dstaddr;
   assign umi_req_out_srcaddr  = u_pkt_if.pkt.srcaddr;
   assign umi_req_out_data     = u_pkt_if.pkt.data;
   assign umi_resp_out_cmd     = u_pkt_if.pkt.cmd;
   assign umi_resp_out_dstaddr = u_pkt_if.pkt.dstaddr;
   assign umi_resp_out_srcaddr = u_pkt_if.pkt.srcaddr;
   assign umi_resp_out_data    = u_pkt_if.pkt.data;

   // Held packet stays put until its port takes it
   a_pkt_hold: assert property (@(posedge clk) disable iff (!nreset)
      u_pkt_if.valid && !u_pkt_if.ready |=> u_pkt_if.valid && $stable(u_pkt_if.pkt));

endmodule

// ==== hdl/lumi_rx.sv ====
`timescale 1ns/1ns
`include "lumi_rx_cfg.svh"

module lumi_rx
(
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 csr_en,              // Low loads local credits
   input  logic [15:0]          csr_crdt_req_init,
   input  logic [15:0]          csr_crdt_resp_init,
   // PHY side
   input  logic [`LUMI_IOW-1:0] phy_rxdata,
   input  logic                 phy_rxvld,
   // Request port
   output logic [`LUMI_CW-1:0]  umi_req_out_cmd,
   output logic [`LUMI_AW-1:0]  umi_req_out_dstaddr,
   output logic [`LUMI_AW-1:0]  umi_req_out_srcaddr,
   output logic [`LUMI_DW-1:0]  umi_req_out_data,
   output logic                 umi_req_out_valid,
   input  logic                 umi_req_out_ready,
   // Response port
   output logic [`LUMI_CW-1:0]  umi_resp_out_cmd,
   output logic [`LUMI_AW-1:0]  umi_resp_out_dstaddr,
   output logic [`LUMI_AW-1:0]  umi_resp_out_srcaddr,
   output logic [`LUMI_DW-1:0]  umi_resp_out_data,
   output logic                 umi_resp_out_valid,
   input  logic                 umi_resp_out_ready,
   // Credits
   output logic [15:0]          loc_crdt_req,        // Sent back to remote side
   output logic [15:0]          loc_crdt_resp,
   output logic [15:0]          rmt_crdt_req,        // Taken from link commands
   output logic [15:0]          rmt_crdt_resp
);

   lumi_rx_pkg::rx_beat_t beat;
   logic                  wr_valid;

   lumi_beat_if u_beat_if ();

   //############################
   // Pipeline stages
   //############################

   lumi_rx_sampler u_sampler
   (
      .clk        (clk),
      .nreset     (nreset),
      .phy_rxdata (phy_rxdata),
      .phy_rxvld  (phy_rxvld),
      .beat       (beat),
      .wr_valid   (wr_valid)
   );

   lumi_rx_queues u_queues
   (
      .clk                (clk),
      .nreset             (nreset),
      .csr_en             (csr_en),
      .csr_crdt_req_init  (csr_crdt_req_init),
      .csr_crdt_resp_init (csr_crdt_resp_init),
      .beat               (beat),
      .wr_valid           (wr_valid),
      .loc_crdt_req       (loc_crdt_req),
      .loc_crdt_resp      (loc_crdt_resp),
      .bif                (u_beat_if)
   );

   lumi_rx_assembler u_assembler
   (
      .clk                  (clk),
      .nreset               (nreset),
      .bif                  (u_beat_if),
      .umi_req_out_cmd      (umi_req_out_cmd),
      .umi_req_out_dstaddr  (umi_req_out_dstaddr),
      .umi_req_out_srcaddr  (umi_req_out_srcaddr),
      .umi_req_out_data     (umi_req_out_data),
      .umi_req_out_valid    (umi_req_out_valid),
      .umi_req_out_ready    (umi_req_out_ready),
      .umi_resp_out_cmd     (umi_resp_out_cmd),
      .umi_resp_out_dstaddr (umi_resp_out_dstaddr),
      .umi_resp_out_srcaddr (umi_resp_out_srcaddr),
      .umi_resp_out_data    (umi_resp_out_data),
      .umi_resp_out_valid   (umi_resp_out_valid),
      .umi_resp_out_ready   (umi_resp_out_ready),
      .rmt_crdt_req         (rmt_crdt_req),
      .rmt_crdt_resp        (rmt_crdt_resp)
   );

endmodule

// ==== testbench/tb_lumi_rx.sv ====
`timescale 1ns/1ns
`include "lumi_rx_cfg.svh"

module tb_lumi_rx;

   localparam int          NPKT      = 12;
   localparam logic [15:0] REQ_INIT  = 16'h0010;   // Local credit start values
   localparam logic [15:0] RESP_INIT = 16'h0020;

   typedef enum logic [1:0] {PORT_REQ, PORT_RESP, PORT_LINK, PORT_DROP} port_t;

   logic                 clk;
   logic                 nreset;
   logic                 csr_en;
   logic [15:0]          csr_crdt_req_init;
   logic [15:0]          csr_crdt_resp_init;
   logic [`LUMI_IOW-1:0] phy_rxdata;
   logic                 phy_rxvld;
   logic [`LUMI_CW-1:0]  umi_req_out_cmd;
   logic [`LUMI_AW-1:0]  umi_req_out_dstaddr;
   logic [`LUMI_AW-1:0]  umi_req_out_srcaddr;
   logic [`LUMI_DW-1:0]  umi_req_out_data;
   logic                 umi_req_out_valid;
   logic                 umi_req_out_ready;
   logic [`LUMI_CW-1:0]  umi_resp_out_cmd;
   logic [`LUMI_AW-1:0]  umi_resp_out_dstaddr;
   logic [`LUMI_AW-1:0]  umi_resp_out_srcaddr;
   logic [`LUMI_DW-1:0]  umi_resp_out_data;
   logic                 umi_resp_out_valid;
   logic                 umi_resp_out_ready;
   logic [15:0]          loc_crdt_req;
   logic [15:0]          loc_crdt_resp;
   logic [15:0]          rmt_crdt_req;
   logic [15:0]          rmt_crdt_resp;

   // Packet table, one column per array
   logic [31:0] t_cmd [NPKT];
   logic [31:0] t_dst [NPKT];
   logic [31:0] t_src [NPKT];
   logic [63:0] t_data [NPKT];
   port_t       t_port [NPKT];
   logic [15:0] t_rmt_req [NPKT];    // Remote credits once the entry is done
   logic [15:0] t_rmt_resp [NPKT];

   lumi_rx_pkg::umi_pkt_t exp_req[$];    // Expected packets per port, in order
   lumi_rx_pkg::umi_pkt_t exp_resp[$];

   integer      seed = 32'ha698afc9;
   logic [31:0] rnd;                     // New random word each edge
   int          n_entries;
   int          total_beats;
   int          errors;
   int          pkts_seen;
   logic        table_done;
   int          req_beats;
   int          resp_beats;

   lumi_rx u_dut (.*);

   always #2 clk = ~clk;

   // Gap and ready source
   always @(posedge clk)
   begin
      rnd                <= $random(seed);
      umi_req_out_ready  <= rnd[0];
      umi_resp_out_ready <= rnd[1];
   end

   //############################
   // Rules and helpers
   //############################

   function automatic logic [31:0] make_cmd(input logic [4:0] op, input logic [2:0] size,
                                            input logic [7:0] len, input logic [15:0] hi);
      return {hi, len, size, op};
   endfunction

   // Header of three beats, then (len+1) << size bytes, cmd-only one beat
   function automatic int beats_of(input logic [31:0] cmd);
      int nbytes;
      nbytes = (int'(cmd[15:8]) + 1) << cmd[7:5];
      case (cmd[4:0])
         `LUMI_OP_WRITE, `LUMI_OP_POSTED, `LUMI_OP_RDRESP: return 3 + nbytes / 4;
         `LUMI_OP_READ, `LUMI_OP_WRRESP:                   return 3;
         default:                                          return 1;
      endcase
   endfunction

   function automatic lumi_rx_pkg::umi_pkt_t expect_pkt(input int idx);
      lumi_rx_pkg::umi_pkt_t p;
      int                    nb;
      nb        = beats_of(t_cmd[idx]);
      p.cmd     = t_cmd[idx];
      p.dstaddr = t_dst[idx];
      p.srcaddr = t_src[idx];
      if (nb <= 3)
         p.data = '0;                            // No data beats sent
      else if (nb == 4)
         p.data = {32'h0, t_data[idx][31:0]};    // Single data beat
      else
         p.data = t_data[idx];
      return p;
   endfunction

   task automatic add_entry(input logic [31:0] cmd, input logic [31:0] dst,
                            input logic [31:0] src, input logic [63:0] data,
                            input port_t port, input logic [15:0] rreq,
                            input logic [15:0] rresp);
      t_cmd[n_entries]      = cmd;
      t_dst[n_entries]      = dst;
      t_src[n_entries]      = src;
      t_data[n_entries]     = data;
      t_port[n_entries]     = port;
      t_rmt_req[n_entries]  = rreq;
      t_rmt_resp[n_entries] = rresp;
      total_beats           = total_beats + beats_of(cmd);
      n_entries++;
   endtask

   task automatic check_field(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (exp !== act)
      begin
         $display("** Error %s: expected %0h, actual %0h", name, exp, act);
         errors++;
      end
   endtask

   task automatic compare_pkt(input string port, input lumi_rx_pkg::umi_pkt_t exp,
                              input logic [31:0] cmd, input logic [31:0] dst,
                              input logic [31:0] src, input logic [63:0] data);
      check_field({port, "_cmd"}, exp.cmd, cmd);
      check_field({port, "_dstaddr"}, exp.dstaddr, dst);
      check_field({port, "_srcaddr"}, exp.srcaddr, src);
      check_field({port, "_data"}, exp.data, data);
   endtask

   // One beat per edge, idle edges where the random word says so
   task automatic drive_pkt(input int idx);
      int          nb;
      logic [31:0] word;
      nb = beats_of(t_cmd[idx]);
      for (int k = 0; k < nb; k++)
      begin
         @(posedge clk);
         while (rnd[5:4] == 2'b00)
         begin
            phy_rxvld <= 1'b0;
            @(posedge clk);
         end
         case (k)
            0:       word = t_cmd[idx];
            1:       word = t_dst[idx];
            2:       word = t_src[idx];
            3:       word = t_data[idx][31:0];
            default: word = t_data[idx][63:32];
         endcase
         phy_rxdata <= word;
         phy_rxvld  <= 1'b1;
      end
   endtask

   // Link commands take effect some cycles after their beat
   task automatic wait_rmt(input int idx);
      int n;
      n = 0;
      @(posedge clk);
      phy_rxvld <= 1'b0;
      while (n < 100 && (rmt_crdt_req !== t_rmt_req[idx] ||
                         rmt_crdt_resp !== t_rmt_resp[idx]))
      begin
         @(posedge clk);
         n++;
      end
      check_field("rmt_crdt_req", t_rmt_req[idx], rmt_crdt_req);
      check_field("rmt_crdt_resp", t_rmt_resp[idx], rmt_crdt_resp);
   endtask

   task automatic fill_table;
      // Request beats total 16, response 13, link 3
      add_entry(make_cmd(`LUMI_OP_WRITE, 3'd2, 8'd1, 16'h0), 32'h1000_0040, 32'h2000_0010,
                64'h8765_4321_dead_beef, PORT_REQ, 16'h0000, 16'h0000);
      add_entry(make_cmd(`LUMI_OP_LINK, 3'd0, `LUMI_CRDT_REQ_A, 16'h0123), 32'h0, 32'h0,
                64'h0, PORT_LINK, 16'h0123, 16'h0000);
      add_entry(make_cmd(`LUMI_OP_RDRESP, 3'd2, 8'd1, 16'h0), 32'h2000_0010, 32'h1000_0040,
                64'h0bad_f00d_1234_5678, PORT_RESP, 16'h0123, 16'h0000);
      add_entry(make_cmd(`LUMI_OP_POSTED, 3'd2, 8'd0, 16'h0), 32'h1000_0080, 32'h2000_0010,
                64'h5555_aaaa_cafe_babe, PORT_REQ, 16'h0123, 16'h0000);
      add_entry(make_cmd(5'd7, 3'd2, 8'd1, 16'h0), 32'h3000_0000, 32'h3000_0004,
                64'h0, PORT_DROP, 16'h0123, 16'h0000);         // Invalid opcode
      add_entry(make_cmd(`LUMI_OP_WRRESP, 3'd2, 8'd1, 16'h0), 32'h2000_0020, 32'h1000_0080,
                64'hffff_0000_ffff_0000, PORT_RESP, 16'h0123, 16'h0000);
      add_entry(make_cmd(`LUMI_OP_LINK, 3'd0, `LUMI_CRDT_RESP_A, 16'h0456), 32'h0, 32'h0,
                64'h0, PORT_LINK, 16'h0123, 16'h0456);
      add_entry(make_cmd(`LUMI_OP_READ, 3'd3, 8'd0, 16'h0), 32'h1000_0100, 32'h2000_0030,
                64'h1111_2222_3333_4444, PORT_REQ, 16'h0123, 16'h0456);
      add_entry(make_cmd(`LUMI_OP_RDRESP, 3'd3, 8'd0, 16'h0), 32'h2000_0030, 32'h1000_0100,
                64'h0f1e_2d3c_4b5a_6978, PORT_RESP, 16'h0123, 16'h0456);
      add_entry(make_cmd(`LUMI_OP_LINK, 3'd0, `LUMI_CRDT_REQ_B, 16'h0789), 32'h0, 32'h0,
                64'h0, PORT_LINK, 16'h0789, 16'h0456);
      add_entry(make_cmd(`LUMI_OP_POSTED, 3'd2, 8'd0, 16'h0), 32'h1000_0200, 32'h2000_0040,
                64'h0000_0000_0246_8ace, PORT_REQ, 16'h0789, 16'h0456);
      add_entry(make_cmd(5'd12, 3'd2, 8'd0, 16'h0), 32'h3000_0008, 32'h3000_000c,
                64'h0, PORT_DROP, 16'h0789, 16'h0456);         // Invalid opcode
   endtask

   //############################
   // Output monitor
   //############################

   always @(posedge clk)
   begin
      if (nreset && umi_req_out_valid && umi_req_out_ready)
      begin
         pkts_seen++;
         if (exp_req.size() == 0)
         begin
            $display("Unexpected packet on the request port, cmd %0h", umi_req_out_cmd);
            errors++;
         end
         else
            compare_pkt("umi_req_out", exp_req.pop_front(), umi_req_out_cmd,
                        umi_req_out_dstaddr, umi_req_out_srcaddr, umi_req_out_data);
      end
      if (nreset && umi_resp_out_valid && umi_resp_out_ready)
      begin
         pkts_seen++;
         if (exp_resp.size() == 0)
         begin
            $display("Unexpected packet on the response port, cmd %0h", umi_resp_out_cmd);
            errors++;
         end
         else
            compare_pkt("umi_resp_out", exp_resp.pop_front(), umi_resp_out_cmd,
                        umi_resp_out_dstaddr, umi_resp_out_srcaddr, umi_resp_out_data);
      end
   end

   // Watchdog, scaled to the table
   initial
   begin
      wait (table_done);
      repeat (total_beats * 20 + 200) @(posedge clk);
      $display("Watchdog expired before all expected packets arrived");
      $display("Something failed");
      $finish;
   end

   //############################
   // Main sequence
   //############################

   initial
   begin
      clk                = 1'b0;
      nreset             = 1'b0;
      csr_en             = 1'b0;
      csr_crdt_req_init  = REQ_INIT;
      csr_crdt_resp_init = RESP_INIT;
      phy_rxdata         = '0;
      phy_rxvld          = 1'b0;
      umi_req_out_ready  = 1'b0;
      umi_resp_out_ready = 1'b0;
      rnd                = '0;
      n_entries          = 0;
      total_beats        = 0;
      errors             = 0;
      pkts_seen          = 0;
      req_beats          = 0;
      resp_beats         = 0;
      fill_table();
      table_done = 1'b1;

      repeat (8) @(posedge clk);
      nreset <= 1'b1;
      repeat (4) @(posedge clk);
      csr_en <= 1'b1;           // Credits count from here

      for (int i = 0; i < NPKT; i++)
      begin
         if (t_port[i] == PORT_REQ)
         begin
            exp_req.push_back(expect_pkt(i));
            req_beats = req_beats + beats_of(t_cmd[i]);
         end
         else if (t_port[i] == PORT_RESP)
         begin
            exp_resp.push_back(expect_pkt(i));
            resp_beats = resp_beats + beats_of(t_cmd[i]);
         end
         drive_pkt(i);
         if (t_port[i] == PORT_LINK)
            wait_rmt(i);
      end
      @(posedge clk);
      phy_rxvld <= 1'b0;

      // Drain both ports, then look for stray packets
      while (exp_req.size() != 0 || exp_resp.size() != 0)
         @(posedge clk);
      repeat (20) @(posedge clk);

      check_field("loc_crdt_req", REQ_INIT + req_beats, loc_crdt_req);
      check_field("loc_crdt_resp", RESP_INIT + resp_beats, loc_crdt_resp);
      check_field("rmt_crdt_req", t_rmt_req[NPKT-1], rmt_crdt_req);
      check_field("rmt_crdt_resp", t_rmt_resp[NPKT-1], rmt_crdt_resp);

      $display("Packets checked %0d, errors %0d", pkts_seen, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/lumi_rx_pkg.sv
hdl/lumi_beat_if.sv
hdl/lumi_pkt_if.sv
hdl/lumi_rx_fifo.sv
hdl/lumi_rx_sampler.sv
hdl/lumi_rx_queues.sv
hdl/lumi_rx_assembler.sv
hdl/lumi_rx.sv
testbench/tb_lumi_rx.sv

// ==== Bender.yml ====
package:
  name: lumi_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/lumi_rx_pkg.sv
      - hdl/lumi_beat_if.sv
      - hdl/lumi_pkt_if.sv
      - hdl/lumi_rx_fifo.sv
      - hdl/lumi_rx_sampler.sv
      - hdl/lumi_rx_queues.sv
      - hdl/lumi_rx_assembler.sv
      - hdl/lumi_rx.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_lumi_rx.sv
